//--- rtl/dma_pkg.sv
package dma_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int LEN_W  = 8;
	localparam int RESP_W = 2;

	// Fixed burst shape, one INCR burst of 16 beats per request
	localparam int BURST_BEATS = 16;
	localparam int BEAT_CNT_W  = 5;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [STRB_W-1:0]     strb_t;
	typedef logic [LEN_W-1:0]      len_t;
	typedef logic [RESP_W-1:0]     resp_t;
	typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

	// AXI length field is beats minus one
	localparam len_t  AWLEN_VAL = len_t'(BURST_BEATS - 1);
	localparam resp_t RESP_OKAY = resp_t'(0);

	typedef enum logic [1:0] {
		AW_IDLE,
		AW_ISSUE,
		AW_BUSY
	} aw_state_t;

	typedef enum logic {
		W_IDLE,
		W_STREAM
	} w_state_t;

	typedef enum logic {
		B_IDLE,
		B_WAIT
	} b_state_t;

endpackage

//--- rtl/dma_aw_issue.sv
`timescale 1ns/10ps

module dma_aw_issue (
	input  logic            clk,
	input  logic            rst,

	// Client request
	input  logic            valid,
	input  dma_pkg::addr_t  addr,

	// AXI write address channel
	output logic            awvalid,
	output dma_pkg::addr_t  awaddr,
	input  logic            awready,

	// Stage handoff
	output logic            burst_start,
	input  logic            burst_done
);

	dma_pkg::aw_state_t state;

	// AW transfer starts the data stage in the same cycle
	assign burst_start = awvalid && awready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= dma_pkg::AW_IDLE;
			awvalid <= 1'b0;
		end else begin
			case (state)
			dma_pkg::AW_IDLE: begin
				if (valid) begin
					state   <= dma_pkg::AW_ISSUE;
					awvalid <= 1'b1;
				end
			end
			dma_pkg::AW_ISSUE: begin
				// Hold the address phase until the slave takes it
				if (awready) begin
					state   <= dma_pkg::AW_BUSY;
					awvalid <= 1'b0;
				end
			end
			dma_pkg::AW_BUSY: begin
				// One burst in flight, wait for its response
				if (burst_done) begin
					state <= dma_pkg::AW_IDLE;
				end
			end
			default: begin
				state   <= dma_pkg::AW_IDLE;
				awvalid <= 1'b0;
			end
			endcase
		end
	end

	// Address captured once per request
	always_ff @(posedge clk) begin
		if (state == dma_pkg::AW_IDLE && valid) begin
			awaddr <= addr;
		end
	end

	// AXI rule for a pending address phase
	a_awaddr_stable: assert property (
		@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(awaddr)
	);

endmodule

//--- rtl/dma_w_beats.sv
`timescale 1ns/10ps

module dma_w_beats (
	input  logic            clk,
	input  logic            rst,

	// Start of burst from the address stage
	input  logic            burst_start,

	// Client data beats
	input  dma_pkg::data_t  wdata,
	input  dma_pkg::strb_t  wstrb,
	output logic            ready,

	// AXI write data channel
	output logic            wvalid,
	output logic            wlast,
	output dma_pkg::data_t  m_wdata,
	output dma_pkg::strb_t  m_wstrb,
	input  logic            wready,

	// Last beat handed to the response stage
	output logic            burst_sent
);

	dma_pkg::w_state_t  state;
	dma_pkg::beat_cnt_t beat_cnt;
	logic               beat_ok;

	localparam dma_pkg::beat_cnt_t LAST_BEAT = dma_pkg::beat_cnt_t'(dma_pkg::BURST_BEATS - 1);

	// Data goes straight through, the client holds it until ready
	assign m_wdata = wdata;
	assign m_wstrb = wstrb;

	assign wvalid  = (state == dma_pkg::W_STREAM);
	assign wlast   = wvalid && (beat_cnt == LAST_BEAT);
	assign beat_ok = wvalid && wready;

	// A client beat is consumed exactly when it moves on AXI
	assign ready      = beat_ok;
	assign burst_sent = beat_ok && wlast;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= dma_pkg::W_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
			dma_pkg::W_IDLE: begin
				if (burst_start) begin
					state    <= dma_pkg::W_STREAM;
					beat_cnt <= '0;
				end
			end
			dma_pkg::W_STREAM: begin
				if (beat_ok) begin
					if (wlast) begin
						state    <= dma_pkg::W_IDLE;
						beat_cnt <= '0;
					end else begin
						beat_cnt <= beat_cnt + 1'b1;
					end
				end
			end
			default: begin
				state    <= dma_pkg::W_IDLE;
				beat_cnt <= '0;
			end
			endcase
		end
	end

	// A stalled beat keeps its place in the burst
	a_w_stall_hold: assert property (
		@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(wlast)
	);

	// Address stage must not start a new burst while data is still streaming
	a_no_overlap: assert property (
		@(posedge clk) disable iff (rst)
		burst_start |-> state != dma_pkg::W_STREAM
	);

endmodule

//--- rtl/dma_b_collect.sv
`timescale 1ns/10ps

module dma_b_collect (
	input  logic            clk,
	input  logic            rst,

	// Last data beat sent
	input  logic            burst_sent,

	// AXI write response channel
	input  logic            bvalid,
	input  dma_pkg::resp_t  bresp,
	output logic            bready,

	// Status
	output logic            error,
	output logic            done,

	// Frees the address stage
	output logic            burst_done
);

	dma_pkg::b_state_t state;
	logic              resp_ok;

	assign bready     = (state == dma_pkg::B_WAIT);
	assign resp_ok    = bvalid && bready;
	assign done       = resp_ok;
	assign burst_done = resp_ok;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= dma_pkg::B_IDLE;
			error <= 1'b0;
		end else begin
			case (state)
			dma_pkg::B_IDLE: begin
				if (burst_sent) begin
					state <= dma_pkg::B_WAIT;
				end
			end
			dma_pkg::B_WAIT: begin
				if (bvalid) begin
					state <= dma_pkg::B_IDLE;
					// Anything but OKAY counts as a failed burst
					error <= (bresp != dma_pkg::RESP_OKAY);
				end
			end
			default: state <= dma_pkg::B_IDLE;
			endcase
		end
	end

	// Slave may only respond after the last beat of the burst
	a_b_in_wait: assert property (
		@(posedge clk) disable iff (rst)
		bvalid |-> state == dma_pkg::B_WAIT
	);

endmodule

//--- rtl/axi_dma_w.sv
`timescale 1ns/10ps

module axi_dma_w (
	input  logic            clk,
	input  logic            rst,

	// Databus
	input  logic            valid,
	input  dma_pkg::addr_t  addr,
	input  dma_pkg::data_t  wdata,
	input  dma_pkg::strb_t  wstrb,
	output logic            ready,

	// AXI write address
	output logic            awvalid,
	output dma_pkg::addr_t  awaddr,
	output dma_pkg::len_t   awlen,
	input  logic            awready,

	// AXI write data
	output logic            wvalid,
	output dma_pkg::data_t  m_wdata,
	output dma_pkg::strb_t  m_wstrb,
	output logic            wlast,
	input  logic            wready,

	// AXI write response
	input  logic            bvalid,
	input  dma_pkg::resp_t  bresp,
	output logic            bready,

	// Status
	output logic            error,
	output logic            done
);

	logic burst_start;
	logic burst_sent;
	logic burst_done;

	// Fixed 16 beat bursts
	assign awlen = dma_pkg::AWLEN_VAL;

	dma_aw_issue dma_aw_issue_inst (
		.clk         (clk),
		.rst         (rst),
		.valid       (valid),
		.addr        (addr),
		.awvalid     (awvalid),
		.awaddr      (awaddr),
		.awready     (awready),
		.burst_start (burst_start),
		.burst_done  (burst_done)
	);

	dma_w_beats dma_w_beats_inst (
		.clk         (clk),
		.rst         (rst),
		.burst_start (burst_start),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.ready       (ready),
		.wvalid      (wvalid),
		.wlast       (wlast),
		.m_wdata     (m_wdata),
		.m_wstrb     (m_wstrb),
		.wready      (wready),
		.burst_sent  (burst_sent)
	);

	dma_b_collect dma_b_collect_inst (
		.clk         (clk),
		.rst         (rst),
		.burst_sent  (burst_sent),
		.bvalid      (bvalid),
		.bresp       (bresp),
		.bready      (bready),
		.error       (error),
		.done        (done),
		.burst_done  (burst_done)
	);

endmodule

//--- bench/tb_axi_dma_w.sv
`timescale 1ns/10ps

module tb_axi_dma_w;

	localparam int NUM_REQ     = 20;
	localparam int BEATS       = 16;
	localparam int STALL_LIMIT = 400;
	localparam dma_pkg::resp_t RESP_SLVERR = 2'b10;

	logic           clk;
	logic           rst;
	logic           valid;
	dma_pkg::addr_t addr;
	dma_pkg::data_t wdata;
	dma_pkg::strb_t wstrb;
	logic           ready;
	logic           awvalid;
	dma_pkg::addr_t awaddr;
	dma_pkg::len_t  awlen;
	logic           awready;
	logic           wvalid;
	dma_pkg::data_t m_wdata;
	dma_pkg::strb_t m_wstrb;
	logic           wlast;
	logic           wready;
	logic           bvalid;
	dma_pkg::resp_t bresp;
	logic           bready;
	logic           error;
	logic           done;

	// Reference model, filled by the request source
	dma_pkg::addr_t exp_addr [NUM_REQ];
	dma_pkg::data_t exp_data [NUM_REQ*BEATS];
	dma_pkg::strb_t exp_strb [NUM_REQ*BEATS];
	dma_pkg::resp_t exp_resp [NUM_REQ];
	logic           exp_error = 1'b0;
	logic           b_expect = 1'b0;
	logic           w_expect = 1'b0;

	logic [31:0] lfsr_state = 32'h8a6ce0f7;

	// Monitor state, sampled at the falling edge
	int   aw_cnt = 0;
	int   w_burst = 0;
	int   w_beat = 0;
	int   rdy_cnt = 0;
	int   done_cnt = 0;
	int   err_cnt = 0;
	logic rdy_s = 1'b0;
	logic bready_s = 1'b0;
	logic b_hs_s = 1'b0;
	logic idle_checked = 1'b0;

	// Source and slave state
	int   src_req = 0;
	int   src_cur = 0;
	int   src_beat = 0;
	logic src_active = 1'b0;
	int   b_cnt = 0;
	int   b_delay = 0;
	logic b_wait = 1'b0;
	int   timeout_cnt = 0;

	axi_dma_w axi_dma_w_inst (
		.clk     (clk),
		.rst     (rst),
		.valid   (valid),
		.addr    (addr),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.ready   (ready),
		.awvalid (awvalid),
		.awaddr  (awaddr),
		.awlen   (awlen),
		.awready (awready),
		.wvalid  (wvalid),
		.m_wdata (m_wdata),
		.m_wstrb (m_wstrb),
		.wlast   (wlast),
		.wready  (wready),
		.bvalid  (bvalid),
		.bresp   (bresp),
		.bready  (bready),
		.error   (error),
		.done    (done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		err_cnt++;
	endtask

	task automatic drive_source();
		int k;
		if (src_active && rdy_s) begin
			src_beat++;
			if (src_beat == BEATS) begin
				src_active = 1'b0;
				valid = 1'b0;
			end
		end
		// New request with a random idle gap
		if (!src_active && src_req < NUM_REQ && rand_bits(1) != 0) begin
			exp_addr[src_req] = rand_bits(32);
			for (k = 0; k < BEATS; k++) begin
				exp_data[src_req*BEATS+k] = rand_bits(32);
				exp_strb[src_req*BEATS+k] = dma_pkg::strb_t'(rand_bits(4));
			end
			exp_resp[src_req] = (rand_bits(1) != 0) ? RESP_SLVERR : dma_pkg::RESP_OKAY;
			addr = exp_addr[src_req];
			valid = 1'b1;
			src_cur = src_req;
			src_beat = 0;
			src_active = 1'b1;
			src_req++;
		end
		if (src_active) begin
			wdata = exp_data[src_cur*BEATS+src_beat];
			wstrb = exp_strb[src_cur*BEATS+src_beat];
		end
	endtask

	task automatic drive_slave();
		awready = (rand_bits(2) != 0);
		wready = (rand_bits(2) != 0);
		if (bvalid && b_hs_s) begin
			bvalid = 1'b0;
			bresp = dma_pkg::RESP_OKAY;
			b_cnt++;
		end else if (!bvalid && bready_s) begin
			if (!b_wait) begin
				b_wait = 1'b1;
				b_delay = rand_bits(3);
			end
			if (b_delay == 0) begin
				bvalid = 1'b1;
				bresp = exp_resp[b_cnt];
				b_wait = 1'b0;
			end else begin
				b_delay--;
			end
		end
	endtask

	task automatic check_idle_outputs();
		if ({awvalid, wvalid, wlast, bready, ready, done, error} !== 7'b0) begin
			report_mismatch("{awvalid,wvalid,wlast,bready,ready,done,error}",
				32'({awvalid, wvalid, wlast, bready, ready, done, error}), 32'h0);
		end
	endtask

	task automatic check_response();
		if (bready !== b_expect)
			report_mismatch("bready", 32'(bready), 32'(b_expect));
		// error holds the last response until the next done
		if (error !== exp_error)
			report_mismatch("error", 32'(error), 32'(exp_error));
		if (done !== (bvalid && b_expect))
			report_mismatch("done", 32'(done), 32'(bvalid && b_expect));
		if (done) begin
			if (w_burst != done_cnt + 1 || w_beat != 0) begin
				$display("Response for request %0d came before all beats", done_cnt);
				err_cnt++;
			end
			if (rdy_cnt != BEATS * (done_cnt + 1))
				report_mismatch("ready pulse count", rdy_cnt, BEATS * (done_cnt + 1));
			exp_error = (exp_resp[done_cnt] != dma_pkg::RESP_OKAY);
			b_expect = 1'b0;
			done_cnt++;
		end
	endtask

	task automatic check_address();
		if (awvalid && aw_cnt != done_cnt) begin
			$display("Second awvalid before done of request %0d", done_cnt);
			err_cnt++;
		end
		if (awvalid && awready) begin
			if (awaddr !== exp_addr[aw_cnt])
				report_mismatch("awaddr", awaddr, exp_addr[aw_cnt]);
			if (awlen !== 8'd15)
				report_mismatch("awlen", 32'(awlen), 32'd15);
			aw_cnt++;
			// Data phase opens on the cycle after the address transfer
			w_expect = 1'b1;
		end
	endtask

	task automatic check_data();
		int idx;
		idx = w_burst * BEATS + w_beat;
		if (wvalid !== w_expect)
			report_mismatch("wvalid", 32'(wvalid), 32'(w_expect));
		if (wlast && !wvalid) begin
			$display("wlast high without wvalid at %0t", $time);
			err_cnt++;
		end
		if (ready !== (w_expect && wready))
			report_mismatch("ready", 32'(ready), 32'(w_expect && wready));
		if (wvalid && w_burst >= aw_cnt) begin
			$display("Write data for burst %0d before its address", w_burst);
			err_cnt++;
		end
		if (wlast !== (w_expect && w_beat == BEATS - 1))
			report_mismatch("wlast", 32'(wlast), 32'(w_expect && w_beat == BEATS - 1));
		if (ready)
			rdy_cnt++;
		if (wvalid && wready) begin
			if (m_wdata !== exp_data[idx])
				report_mismatch("m_wdata", m_wdata, exp_data[idx]);
			if (m_wstrb !== exp_strb[idx])
				report_mismatch("m_wstrb", 32'(m_wstrb), 32'(exp_strb[idx]));
			w_beat++;
			if (w_beat == BEATS) begin
				w_beat = 0;
				w_burst++;
				w_expect = 1'b0;
				b_expect = 1'b1;
			end
		end
	endtask

	// Outputs are settled mid cycle, handshakes complete on the next rising edge
	always @(negedge clk) begin
		if (!rst) begin
			if (!idle_checked) begin
				check_idle_outputs();
				idle_checked = 1'b1;
			end
			check_response();
			check_data();
			check_address();
			rdy_s = ready;
			bready_s = bready;
			b_hs_s = bvalid && bready;
		end
	end

	task automatic finish_run();
		$display("Requests done %0d of %0d, check errors %0d, timeouts %0d",
			done_cnt, NUM_REQ, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0 && done_cnt == NUM_REQ)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	initial begin
		int stall;
		int last_done;
		stall = 0;
		last_done = 0;
		rst = 1'b1;
		valid = 1'b0;
		addr = '0;
		wdata = '0;
		wstrb = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = dma_pkg::RESP_OKAY;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		while (done_cnt < NUM_REQ && timeout_cnt == 0) begin
			@(posedge clk);
			#2;
			drive_source();
			drive_slave();
			if (done_cnt != last_done) begin
				last_done = done_cnt;
				stall = 0;
			end else begin
				stall++;
			end
			if (stall > STALL_LIMIT) begin
				$display("Timeout waiting for request %0d to complete", done_cnt);
				timeout_cnt++;
			end
		end
		// Let the error level of the last response be checked
		@(negedge clk);
		@(negedge clk);
		finish_run();
	end

endmodule

//--- src.f
rtl/dma_pkg.sv
rtl/dma_aw_issue.sv
rtl/dma_w_beats.sv
rtl/dma_b_collect.sv
rtl/axi_dma_w.sv
bench/tb_axi_dma_w.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_dma_w
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
